// File: hw/pcxt_audio_pkg.sv
/* PC/XT audio path definitions */

package pcxt_audio_pkg;

	//////////////////////////////
	// Sample and mix widths
	//////////////////////////////

	localparam int SAMPLE_W = 16;
	localparam int MIX_W    = 17;
	localparam int TANDY_W  = 8;
	localparam int VOL_W    = 2;

	// Signed two's complement audio word
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// One bit of headroom over a sample for the sum
	typedef logic signed [MIX_W-1:0] mix_t;

	// Raw Tandy PSG output, unsigned
	typedef logic [TANDY_W-1:0] tandy_t;

	// Audio boost selection, value 3 behaves like 4x
	typedef enum logic [1:0] {
		BOOST_NONE = 2'd0,
		BOOST_2X   = 2'd1,
		BOOST_4X   = 2'd2
	} boost_t;

	//////////////////////////////
	// Compressor curves
	//////////////////////////////

	// 2x curve: gain A below knee X, slope 1/F above it
	localparam int COMP_F1 = 4;
	localparam int COMP_A1 = 2;
	localparam int COMP_X1 = ((32767 * (COMP_F1 - 1)) / ((COMP_F1 * COMP_A1) - 1)) + 1;
	localparam int COMP_B1 = COMP_X1 * COMP_A1;

	// 4x curve
	localparam int COMP_F2 = 8;
	localparam int COMP_A2 = 4;
	localparam int COMP_X2 = ((32767 * (COMP_F2 - 1)) / ((COMP_F2 * COMP_A2) - 1)) + 1;
	localparam int COMP_B2 = COMP_X2 * COMP_A2;

	// Placement of the small sources inside the mix
	localparam int TANDY_SHIFT   = 4;
	localparam int SPEAKER_SHIFT = 11;

endpackage

// File: hw/sample_settle.sv
/* Sample word settle filter */

`timescale 1ns/1ps

module sample_settle #(
	parameter type payload_t = logic [15:0]
) (
	input  logic     clk_chipset,
	input  logic     reset,
	input  payload_t sample_in,
	output payload_t sample_out
);

	// Two most recent input words
	payload_t history_0;
	payload_t history_1;

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			history_0  <= '0;
			history_1  <= '0;
			sample_out <= '0;
		end else begin
			history_0 <= sample_in;
			history_1 <= history_0;
			// Only a word seen twice in a row is taken
			if (history_0 == history_1) begin
				sample_out <= history_1;
			end
		end
	end

endmodule

// File: hw/audio_source_scaler.sv
/* Audio source conditioning */

`timescale 1ns/1ps

module audio_source_scaler (
	input  logic                             clk_chipset,
	input  logic                             reset,
	input  pcxt_audio_pkg::sample_t          opl2_sample,
	input  pcxt_audio_pkg::tandy_t           tandy_sample,
	input  logic                             speaker_level,
	input  logic [pcxt_audio_pkg::VOL_W-1:0] speaker_volume,
	input  logic [pcxt_audio_pkg::VOL_W-1:0] tandy_volume,
	output pcxt_audio_pkg::mix_t             opl2_term,
	output pcxt_audio_pkg::mix_t             tandy_term,
	output pcxt_audio_pkg::mix_t             speaker_term
);

	pcxt_audio_pkg::sample_t opl2_settled;
	pcxt_audio_pkg::tandy_t  tandy_settled;

	// Control inputs, first two stages
	logic                             spk_level_d1;
	logic                             spk_level_d2;
	logic [pcxt_audio_pkg::VOL_W-1:0] spk_vol_d1;
	logic [pcxt_audio_pkg::VOL_W-1:0] spk_vol_d2;
	logic [pcxt_audio_pkg::VOL_W-1:0] tandy_vol_d1;
	logic [pcxt_audio_pkg::VOL_W-1:0] tandy_vol_d2;

	// Third stage, in step with the settled samples
	pcxt_audio_pkg::mix_t             speaker_pre;
	logic [pcxt_audio_pkg::VOL_W-1:0] tandy_vol_d3;

	//////////////////////////////
	// Glitch filters
	//////////////////////////////

	sample_settle #(
		.payload_t(pcxt_audio_pkg::sample_t)
	) opl2_settle (
		.clk_chipset(clk_chipset),
		.reset      (reset),
		.sample_in  (opl2_sample),
		.sample_out (opl2_settled)
	);

	sample_settle #(
		.payload_t(pcxt_audio_pkg::tandy_t)
	) tandy_settle (
		.clk_chipset(clk_chipset),
		.reset      (reset),
		.sample_in  (tandy_sample),
		.sample_out (tandy_settled)
	);

	//////////////////////////////
	// Volume and term pipeline
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			spk_level_d1 <= 1'b0;
			spk_level_d2 <= 1'b0;
			spk_vol_d1   <= '0;
			spk_vol_d2   <= '0;
			tandy_vol_d1 <= '0;
			tandy_vol_d2 <= '0;
			tandy_vol_d3 <= '0;
			speaker_pre  <= '0;
			opl2_term    <= '0;
			tandy_term   <= '0;
			speaker_term <= '0;
		end else begin
			spk_level_d1 <= speaker_level;
			spk_level_d2 <= spk_level_d1;
			spk_vol_d1   <= speaker_volume;
			spk_vol_d2   <= spk_vol_d1;
			tandy_vol_d1 <= tandy_volume;
			tandy_vol_d2 <= tandy_vol_d1;
			tandy_vol_d3 <= tandy_vol_d2;
			// Low level drives the cone
			speaker_pre  <= spk_level_d2 ? '0 :
				(pcxt_audio_pkg::mix_t'(1) << spk_vol_d2) << pcxt_audio_pkg::SPEAKER_SHIFT;
			opl2_term    <= {opl2_settled[pcxt_audio_pkg::SAMPLE_W-1], opl2_settled};
			tandy_term   <= ({{(pcxt_audio_pkg::MIX_W - pcxt_audio_pkg::TANDY_W){1'b0}},
				tandy_settled} << tandy_vol_d3) << pcxt_audio_pkg::TANDY_SHIFT;
			speaker_term <= speaker_pre;
		end
	end

endmodule

// File: hw/audio_mixer.sv
/* Three source mixer */

`timescale 1ns/1ps

module audio_mixer (
	input  logic                    clk_chipset,
	input  logic                    reset,
	input  pcxt_audio_pkg::mix_t    opl2_term,
	input  pcxt_audio_pkg::mix_t    tandy_term,
	input  pcxt_audio_pkg::mix_t    speaker_term,
	output pcxt_audio_pkg::sample_t mixed
);

	// Raw sum, wraps at 17 bits
	pcxt_audio_pkg::mix_t sum;

	// Top two bits disagree when the sum left 16-bit range
	logic overflow;

	// Saturation limits
	pcxt_audio_pkg::sample_t sat_value;

	assign overflow = sum[pcxt_audio_pkg::MIX_W-1] ^ sum[pcxt_audio_pkg::MIX_W-2];

	// Sign of the sum picks the rail
	assign sat_value = {sum[pcxt_audio_pkg::MIX_W-1],
		{(pcxt_audio_pkg::SAMPLE_W-1){~sum[pcxt_audio_pkg::MIX_W-1]}}};

	//////////////////////////////
	// Sum stage
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			sum <= '0;
		end else begin
			sum <= opl2_term + tandy_term + speaker_term;
		end
	end

	//////////////////////////////
	// Clamp stage
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			mixed <= '0;
		end else if (overflow) begin
			mixed <= sat_value;
		end else begin
			mixed <= sum[pcxt_audio_pkg::SAMPLE_W-1:0];
		end
	end

endmodule

// File: hw/audio_compressor.sv
/* Audio boost compressor */

`timescale 1ns/1ps

module audio_compressor (
	input  logic                    clk_chipset,
	input  logic                    reset,
	input  pcxt_audio_pkg::sample_t mixed,
	input  pcxt_audio_pkg::boost_t  boost_mode,
	output pcxt_audio_pkg::sample_t audio_out
);

	// Input magnitude with 0x8000 for the most negative value
	logic [pcxt_audio_pkg::SAMPLE_W-1:0] magnitude;

	// Both curves evaluated in parallel
	logic [pcxt_audio_pkg::SAMPLE_W-1:0] curve_2x;
	logic [pcxt_audio_pkg::SAMPLE_W-1:0] curve_4x;
	logic [pcxt_audio_pkg::SAMPLE_W-1:0] shaped;

	// Shaped magnitude with the sign put back
	logic [pcxt_audio_pkg::SAMPLE_W-1:0] boosted;

	logic negative;

	//////////////////////////////
	// Curve shape
	//////////////////////////////

	// Linear gain below the knee and a flat slope above it with 16-bit wrap
	function automatic logic [pcxt_audio_pkg::SAMPLE_W-1:0] apply_curve(
		input logic [pcxt_audio_pkg::SAMPLE_W-1:0] mag,
		input logic [pcxt_audio_pkg::SAMPLE_W-1:0] knee,
		input logic [pcxt_audio_pkg::SAMPLE_W-1:0] gain,
		input logic [pcxt_audio_pkg::SAMPLE_W-1:0] slope_div,
		input logic [pcxt_audio_pkg::SAMPLE_W-1:0] knee_out
	);
		logic [pcxt_audio_pkg::SAMPLE_W-1:0] result;
		if (mag < knee) begin
			result = mag * gain;
		end else begin
			result = ((mag - knee) / slope_div) + knee_out;
		end
		return result;
	endfunction

	assign negative  = mixed[pcxt_audio_pkg::SAMPLE_W-1];
	assign magnitude = negative ? (~mixed + 16'd1) : mixed;

	assign curve_2x = apply_curve(magnitude,
		16'(pcxt_audio_pkg::COMP_X1), 16'(pcxt_audio_pkg::COMP_A1),
		16'(pcxt_audio_pkg::COMP_F1), 16'(pcxt_audio_pkg::COMP_B1));

	assign curve_4x = apply_curve(magnitude,
		16'(pcxt_audio_pkg::COMP_X2), 16'(pcxt_audio_pkg::COMP_A2),
		16'(pcxt_audio_pkg::COMP_F2), 16'(pcxt_audio_pkg::COMP_B2));

	// Modes 2 and 3 both take the 4x curve
	assign shaped  = (boost_mode == pcxt_audio_pkg::BOOST_2X) ? curve_2x : curve_4x;
	assign boosted = negative ? ~(shaped - 16'd1) : shaped;

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			audio_out <= '0;
		end else if (boost_mode == pcxt_audio_pkg::BOOST_NONE) begin
			audio_out <= mixed;
		end else begin
			audio_out <= pcxt_audio_pkg::sample_t'(boosted);
		end
	end

endmodule

// File: hw/pcxt_audio.sv
/* PC/XT audio path top */

`timescale 1ns/1ps

module pcxt_audio (
	input  logic                             clk_chipset,
	input  logic                             reset,
	// Sources
	input  pcxt_audio_pkg::sample_t          opl2_sample,
	input  pcxt_audio_pkg::tandy_t           tandy_sample,
	input  logic                             speaker_level,
	// Settings
	input  logic [pcxt_audio_pkg::VOL_W-1:0] speaker_volume,
	input  logic [pcxt_audio_pkg::VOL_W-1:0] tandy_volume,
	input  pcxt_audio_pkg::boost_t           boost_mode,
	// Mixed and boosted result, 7 clocks behind the inputs
	output pcxt_audio_pkg::sample_t          audio_out
);

	// Terms from the input side, 4 clocks in
	pcxt_audio_pkg::mix_t opl2_term;
	pcxt_audio_pkg::mix_t tandy_term;
	pcxt_audio_pkg::mix_t speaker_term;

	// Clamped sum, 6 clocks in
	pcxt_audio_pkg::sample_t mixed;

	//////////////////////////////
	// Input side
	//////////////////////////////

	audio_source_scaler source_scaler (
		.clk_chipset   (clk_chipset),
		.reset         (reset),
		.opl2_sample   (opl2_sample),
		.tandy_sample  (tandy_sample),
		.speaker_level (speaker_level),
		.speaker_volume(speaker_volume),
		.tandy_volume  (tandy_volume),
		.opl2_term     (opl2_term),
		.tandy_term    (tandy_term),
		.speaker_term  (speaker_term)
	);

	//////////////////////////////
	// Sum and clamp
	//////////////////////////////

	audio_mixer mixer (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.opl2_term   (opl2_term),
		.tandy_term  (tandy_term),
		.speaker_term(speaker_term),
		.mixed       (mixed)
	);

	//////////////////////////////
	// Output side
	//////////////////////////////

	audio_compressor compressor (
		.clk_chipset(clk_chipset),
		.reset      (reset),
		.mixed      (mixed),
		.boost_mode (boost_mode),
		.audio_out  (audio_out)
	);

endmodule

// File: bench/tb_clock_gen.sv
/* Testbench clock source */

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_chipset
);

	// 100 ns period
	initial begin
		clk_chipset = 1'b0;
	end

	always begin
		#50;
		clk_chipset = ~clk_chipset;
	end

endmodule

// File: bench/pcxt_audio_props.sv
/* Compressor output checks */

`timescale 1ns/1ps

module pcxt_audio_props (
	input logic                    clk_chipset,
	input logic                    reset,
	input pcxt_audio_pkg::sample_t mixed,
	input pcxt_audio_pkg::boost_t  boost_mode,
	input pcxt_audio_pkg::sample_t audio_out
);

	// Output held at zero during reset
	reset_clears_output: assert property (@(posedge clk_chipset)
		reset |-> audio_out == '0)
		else $error("audio_out is not zero while reset is high");

	// No boost means a plain register
	passthrough_when_off: assert property (@(posedge clk_chipset) disable iff (reset)
		($past(boost_mode) == pcxt_audio_pkg::BOOST_NONE) |-> (audio_out == $past(mixed)))
		else $error("audio_out differs from mixed with boost off");

	// Curves wrap near full scale, so the rails are left out
	boost_keeps_sign: assert property (@(posedge clk_chipset) disable iff (reset)
		(($past(boost_mode) != pcxt_audio_pkg::BOOST_NONE) &&
		 ($past(mixed) > -32000) && ($past(mixed) < 32000) && (audio_out != '0))
		|-> (audio_out[pcxt_audio_pkg::SAMPLE_W-1] == $past(mixed[pcxt_audio_pkg::SAMPLE_W-1])))
		else $error("boosted audio_out has the wrong sign");

endmodule

bind audio_compressor pcxt_audio_props compressor_props (
	.clk_chipset(clk_chipset),
	.reset      (reset),
	.mixed      (mixed),
	.boost_mode (boost_mode),
	.audio_out  (audio_out)
);

// File: bench/tb_pcxt_audio.sv
/* PC/XT audio path testbench */

`timescale 1ns/1ps

module tb_pcxt_audio;

	localparam int RESET_CYCLES = 10;
	localparam int HOLD_CYCLES  = 10;
	localparam int CHECK_CYCLE  = 9;
	localparam int NUM_OPL2     = 20;
	localparam int NUM_VOLUME   = 16;
	localparam int NUM_OVERFLOW = 6;
	localparam int NUM_KNEES    = 12;
	localparam int NUM_BOOST    = 40;
	localparam int NUM_GLITCH   = 4;
	localparam int NUM_RANDOM   = 60;
	// A glitch test takes two vector slots
	localparam int NUM_VECTORS  = 1 + NUM_OPL2 + NUM_VOLUME + NUM_OVERFLOW + NUM_KNEES +
		NUM_BOOST + (2 * NUM_GLITCH) + NUM_RANDOM;
	localparam int CYCLE_LIMIT  = (NUM_VECTORS * HOLD_CYCLES) + RESET_CYCLES + 50;

	logic                             clk_chipset;
	logic                             reset;
	pcxt_audio_pkg::sample_t          opl2_sample;
	pcxt_audio_pkg::tandy_t           tandy_sample;
	logic                             speaker_level;
	logic [pcxt_audio_pkg::VOL_W-1:0] speaker_volume;
	logic [pcxt_audio_pkg::VOL_W-1:0] tandy_volume;
	pcxt_audio_pkg::boost_t           boost_mode;
	pcxt_audio_pkg::sample_t          audio_out;

	int seed        = 99444;
	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;

	tb_clock_gen clock_gen (
		.clk_chipset(clk_chipset)
	);

	pcxt_audio i_dut (
		.clk_chipset   (clk_chipset),
		.reset         (reset),
		.opl2_sample   (opl2_sample),
		.tandy_sample  (tandy_sample),
		.speaker_level (speaker_level),
		.speaker_volume(speaker_volume),
		.tandy_volume  (tandy_volume),
		.boost_mode    (boost_mode),
		.audio_out     (audio_out)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Scaled sum, wrapped to 17 bits and clamped to a sample
	function automatic int mix_model(input int opl2, input int tandy, input int spk_level,
		input int spk_vol, input int tandy_vol);
		int tandy_part;
		int speaker_part;
		int sum17;
		int low16;
		int result;
		tandy_part   = (tandy << tandy_vol) << pcxt_audio_pkg::TANDY_SHIFT;
		speaker_part = (spk_level != 0) ? 0 : ((1 << spk_vol) << pcxt_audio_pkg::SPEAKER_SHIFT);
		sum17        = (opl2 + tandy_part + speaker_part) & 32'h0001FFFF;
		low16        = sum17 & 32'h0000FFFF;
		if (sum17[16] != sum17[15]) begin
			result = sum17[16] ? -32768 : 32767;
		end else begin
			result = (low16 >= 32768) ? (low16 - 65536) : low16;
		end
		return result;
	endfunction

	// Two-curve boost on a signed sample
	function automatic int compress_model(input int sample, input int boost);
		int f;
		int a;
		int x;
		int b;
		int mag;
		int shaped;
		int result;
		if (boost == 1) begin
			f = pcxt_audio_pkg::COMP_F1;
			a = pcxt_audio_pkg::COMP_A1;
			x = pcxt_audio_pkg::COMP_X1;
			b = pcxt_audio_pkg::COMP_B1;
		end else begin
			f = pcxt_audio_pkg::COMP_F2;
			a = pcxt_audio_pkg::COMP_A2;
			x = pcxt_audio_pkg::COMP_X2;
			b = pcxt_audio_pkg::COMP_B2;
		end
		mag = (sample < 0) ? -sample : sample;
		if (mag < x) begin
			shaped = (mag * a) & 32'h0000FFFF;
		end else begin
			shaped = (((mag - x) / f) + b) & 32'h0000FFFF;
		end
		if (sample < 0) begin
			shaped = (-shaped) & 32'h0000FFFF;
		end
		if (boost == 0) begin
			result = sample;
		end else begin
			result = (shaped >= 32768) ? (shaped - 65536) : shaped;
		end
		return result;
	endfunction

	function automatic int expected_audio();
		int mix;
		mix = mix_model(int'(opl2_sample), int'(tandy_sample), int'(speaker_level),
			int'(speaker_volume), int'(tandy_volume));
		return compress_model(mix, int'(boost_mode));
	endfunction

	function automatic int random_below(input int limit);
		int r;
		r = $random(seed) & 32'h7FFFFFFF;
		return r % limit;
	endfunction

	//////////////////////////////
	// Drive and check
	//////////////////////////////

	task automatic check_value(input string name, input int actual, input int expected);
		check_count++;
		if (actual != expected) begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s = %0d, expected %0d",
				$time, name, actual, expected);
		end
	endtask

	task automatic drive_inputs(input int opl2, input int tandy, input int spk_level,
		input int spk_vol, input int tandy_vol, input int boost);
		opl2_sample    = pcxt_audio_pkg::sample_t'(opl2);
		tandy_sample   = pcxt_audio_pkg::tandy_t'(tandy);
		speaker_level  = spk_level[0];
		speaker_volume = spk_vol[pcxt_audio_pkg::VOL_W-1:0];
		tandy_volume   = tandy_vol[pcxt_audio_pkg::VOL_W-1:0];
		boost_mode     = pcxt_audio_pkg::boost_t'(boost[1:0]);
	endtask

	// Checked on the 9th clock, next vector goes in after the 10th
	task automatic hold_and_check();
		repeat (CHECK_CYCLE) @(posedge clk_chipset);
		#1;
		check_value("audio_out", int'(audio_out), expected_audio());
		@(posedge clk_chipset);
		#1;
	endtask

	task automatic apply_vector(input int opl2, input int tandy, input int spk_level,
		input int spk_vol, input int tandy_vol, input int boost);
		drive_inputs(opl2, tandy, spk_level, spk_vol, tandy_vol, boost);
		hold_and_check();
	endtask

	task automatic random_vector(input int min_boost);
		int boost;
		boost = min_boost + random_below(4 - min_boost);
		apply_vector(random_below(65536) - 32768, random_below(256), random_below(2),
			random_below(4), random_below(4), boost);
	endtask

	// Mixes just below and at the knee, both signs, and both rails
	task automatic boost_knees(input int boost, input int knee);
		apply_vector(knee - 1, 0, 1, 0, 0, boost);
		apply_vector(knee, 0, 1, 0, 0, boost);
		apply_vector(1 - knee, 0, 1, 0, 0, boost);
		apply_vector(-knee, 0, 1, 0, 0, boost);
		apply_vector(-32768, 0, 1, 0, 0, boost);
		apply_vector(32767, 0, 1, 0, 0, boost);
	endtask

	// One-clock OPL2 spike must be filtered out
	task automatic glitch_opl2();
		int old_value;
		int spike;
		old_value = random_below(65536) - 32768;
		spike     = old_value ^ (1 + random_below(65535));
		apply_vector(old_value, random_below(256), random_below(2), random_below(4),
			random_below(4), random_below(4));
		opl2_sample = pcxt_audio_pkg::sample_t'(spike);
		@(posedge clk_chipset);
		#1;
		opl2_sample = pcxt_audio_pkg::sample_t'(old_value);
		repeat (HOLD_CYCLES - 1) begin
			@(posedge clk_chipset);
			#1;
			check_value("audio_out", int'(audio_out), expected_audio());
		end
	endtask

	//////////////////////////////
	// Timeout
	//////////////////////////////

	always @(posedge clk_chipset) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("ERROR: run timed out after %0d cycles", cycle_count);
			$display("Checks run: %0d, errors: %0d", check_count, error_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		reset = 1'b1;
		drive_inputs(0, 0, 1, 0, 0, 0);
		repeat (RESET_CYCLES) @(posedge clk_chipset);
		#1;
		check_value("audio_out", int'(audio_out), 0);
		reset = 1'b0;

		// Idle after reset
		apply_vector(0, 0, 1, 0, 0, 0);

		// OPL2 alone, no boost
		repeat (NUM_OPL2) begin
			apply_vector(random_below(65536) - 32768, 0, 1, random_below(4),
				random_below(4), 0);
		end

		// Every volume pair with the speaker driven
		for (int sv = 0; sv < 4; sv++) begin
			for (int tv = 0; tv < 4; tv++) begin
				apply_vector(0, random_below(256), 0, sv, tv, 0);
			end
		end

		// Overflow and clamp
		apply_vector(32767, 255, 0, 0, 0, 0);
		apply_vector(30000, 200, 0, 1, 1, 0);
		apply_vector(32767, 255, 0, 3, 3, 0);
		apply_vector(-32768, 0, 1, 0, 0, 0);
		apply_vector(-32768, 0, 0, 0, 0, 0);
		apply_vector(-30000, 255, 0, 3, 3, 0);

		boost_knees(1, pcxt_audio_pkg::COMP_X1);
		boost_knees(2, pcxt_audio_pkg::COMP_X2);

		repeat (NUM_BOOST) begin
			random_vector(1);
		end

		repeat (NUM_GLITCH) begin
			glitch_opl2();
		end

		repeat (NUM_RANDOM) begin
			random_vector(0);
		end

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: pcxt_audio.f
hw/pcxt_audio_pkg.sv
hw/sample_settle.sv
hw/audio_source_scaler.sv
hw/audio_mixer.sv
hw/audio_compressor.sv
hw/pcxt_audio.sv
bench/tb_clock_gen.sv
bench/pcxt_audio_props.sv
bench/tb_pcxt_audio.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pcxt_audio testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_pcxt_audio -f pcxt_audio.f \
	--Mdir obj_dir -o sim_pcxt_audio
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/sim_pcxt_audio)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -q "RESULT: PASS"; then
	exit 0
fi
exit 1
